// File: tb.f
+incdir+include
src/regFilePkg.sv
src/regBankIf.sv
src/regLoadDecoder.sv
src/gpRegister.sv
src/regReadMux.sv
src/registerFile.sv
dv/tbClock.sv
dv/registerFile_properties.sv
dv/registerFileTb.sv

// File: Makefile
# Verilator build and run of the register file testbench.

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f tb.f --top-module registerFileTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: dv/registerFileTb.sv
`timescale 1ns/1ps

`include "regFile_config.svh"

module registerFileTb import regFilePkg::*; ();

	localparam int randomCycles = 600;
	localparam int timeoutCycles = 800; // 5 reset, 40 directed, 600 random, plus margin.

	logic     CLK;
	logic     rst;
	dataWordT inAlu;
	dataWordT inMem;
	dataWordT inPipe;
	regMaskT  ldAlu;
	regMaskT  ldMem;
	regMaskT  ldPipe;
	regMaskT  inc;
	regIdxT   aluASel;
	regIdxT   aluBSel;
	regIdxT   memSel;
	regIdxT   memAddrSel;
	logic     aluBFromPipe;
	logic     memEn;
	dataWordT aluA;
	dataWordT aluB;
	dataWordT memData;
	dataWordT memAddr;

	dataWordT model [`RF_NUM_REGS]; // Expected register contents.
	int       cycles = 0; // Rising edges so far.
	int       checks = 0;
	int       errors = 0;

	tbClock clockGen (.CLK (CLK), .rst (rst));

	registerFile dut (.*); // Local names match the ports.

	// Value of register r after the coming edge.
	function automatic dataWordT nextRegValue(input regIdxT r);
		if (ldAlu[r]) return inAlu; // ALU beats memory.
		if (ldMem[r]) return inMem; // Memory beats pipeline.
		if (ldPipe[r]) return inPipe;
		if (inc[r]) return model[r] + dataWordT'(1); // Only when no load names r.
		return model[r];
	endfunction

	// Read ports as the model and the current selects predict them.
	function automatic void expectPorts(output dataWordT a, output dataWordT b,
		output dataWordT md, output dataWordT ma);
		a  = model[aluASel];
		b  = aluBFromPipe ? inPipe : model[aluBSel]; // Constant bypass.
		md = memEn ? model[memSel] : '0; // Zero while memory is idle.
		ma = model[memAddrSel];
	endfunction

	task automatic checkWord(input string name, input dataWordT exp, input dataWordT act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("** Error: %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic comparePorts();
		dataWordT expA;
		dataWordT expB;
		dataWordT expMd;
		dataWordT expMa;
		expectPorts(expA, expB, expMd, expMa);
		checkWord("aluA", expA, aluA);
		checkWord("aluB", expB, aluB);
		checkWord("memData", expMd, memData);
		checkWord("memAddr", expMa, memAddr);
	endtask

	task automatic clearStrobes();
		ldAlu  = '0;
		ldMem  = '0;
		ldPipe = '0;
		inc    = '0;
	endtask

	// One register on all four ports, no bypass, memory enabled.
	task automatic selectAll(input regIdxT r);
		aluASel      = r;
		aluBSel      = r;
		memSel       = r;
		memAddrSel   = r;
		aluBFromPipe = 1'b0;
		memEn        = 1'b1;
	endtask

	task automatic randomWords();
		inAlu  = dataWordT'($urandom);
		inMem  = dataWordT'($urandom);
		inPipe = dataWordT'($urandom);
	endtask

	// Model steps with the DUT at every rising edge.
	always @(posedge CLK)
	begin
		cycles++;
		for (int i = 0; i < `RF_NUM_REGS; i++)
			model[i] = rst ? '0 : nextRegValue(regIdxT'(i));
	end

	// Halfway between the drive and the next rising edge.
	always @(negedge CLK)
	begin
		#10;
		if (!rst)
			comparePorts();
	end

	initial
	begin
		wait (cycles >= timeoutCycles);
		$display("Timeout: the run did not end within %0d cycles", timeoutCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		void'($urandom(38)); // Single seed for the run.
		clearStrobes();
		randomWords();
		selectAll('0);
		wait (!rst);

		// Cleared bank on every select.
		for (int k = 0; k < 8; k++)
		begin
			selectAll(regIdxT'(k));
			@(negedge CLK);
		end

		// Each register from each source is read back on the next cycle.
		for (int s = 0; s < 3; s++)
			for (int i = 0; i < `RF_NUM_REGS; i++)
			begin
				clearStrobes();
				randomWords();
				case (s)
					0:       ldAlu  = regMaskT'(1 << i);
					1:       ldMem  = regMaskT'(1 << i);
					default: ldPipe = regMaskT'(1 << i);
				endcase
				selectAll(regIdxT'(i - 1)); // Register loaded one cycle earlier.
				@(negedge CLK);
			end

		// Colliding strobes on registers 0 to 3.
		randomWords();
		selectAll(3'd7); // Last pipeline load.
		ldAlu  = 8'h01;
		ldMem  = 8'h03;
		ldPipe = 8'h07;
		inc    = 8'h0F; // Register 3 only increments.
		@(negedge CLK);
		clearStrobes();
		aluASel    = 3'd0; // ALU word.
		aluBSel    = 3'd1; // Memory word.
		memSel     = 3'd2; // Pipeline word.
		memAddrSel = 3'd3; // Old word plus one.
		@(negedge CLK);

		// FFFF into register 4 despite an increment, then wrap through zero.
		selectAll(3'd4);
		inAlu = 16'hFFFF;
		ldAlu = 8'h10;
		inc   = 8'h10;
		@(negedge CLK);
		ldAlu = '0;
		repeat (2) @(negedge CLK);
		inc = '0;
		@(negedge CLK);

		// Bypass on and off with the memory port idle.
		for (int k = 0; k < 2; k++)
		begin
			randomWords();
			selectAll(regIdxT'(k));
			aluBFromPipe = (k == 0);
			memEn        = 1'b0;
			@(negedge CLK);
		end

		// Random traffic with ANDed masks to keep the loads sparse.
		repeat (randomCycles)
		begin
			randomWords();
			ldAlu        = regMaskT'($urandom & $urandom);
			ldMem        = regMaskT'($urandom & $urandom);
			ldPipe       = regMaskT'($urandom & $urandom);
			inc          = regMaskT'($urandom);
			aluASel      = regIdxT'($urandom);
			aluBSel      = regIdxT'($urandom);
			memSel       = regIdxT'($urandom);
			memAddrSel   = regIdxT'($urandom);
			aluBFromPipe = 1'($urandom);
			memEn        = 1'($urandom);
			@(negedge CLK);
		end

		$display("Checks: %0d, mismatches: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: dv/registerFile_properties.sv
`timescale 1ns/1ps

`include "regFile_config.svh"

module registerFile_properties import regFilePkg::*;
(
	input logic     CLK,
	input logic     rst,
	input logic     aluBFromPipe,
	input logic     memEn,
	input dataWordT inPipe,
	input dataWordT aluB,
	input dataWordT memData,
	input dataWordT regValue [`RF_NUM_REGS] // Register contents from the bank.
);

	logic anyNonZero; // Some register holds a nonzero word.

	always_comb
	begin
		anyNonZero = 1'b0;
		for (int i = 0; i < `RF_NUM_REGS; i++)
			anyNonZero = anyNonZero | (regValue[i] != '0);
	end

	// Memory data port reads zero while disabled.
	memDataGated: assert property (@(posedge CLK) !memEn |-> memData == '0)
		else $error("memData is nonzero while memEn is low");

	// Operand B follows the constant during a bypass.
	aluBBypass: assert property (@(posedge CLK) aluBFromPipe |-> aluB == inPipe)
		else $error("aluB does not follow inPipe during the bypass");

	// First cycle out of reset sees a cleared bank.
	clearedByReset: assert property (@(posedge CLK) $fell(rst) |-> !anyNonZero)
		else $error("a register is not cleared by reset");

endmodule

bind registerFile registerFile_properties props (
	.CLK          (CLK),
	.rst          (rst),
	.aluBFromPipe (aluBFromPipe),
	.memEn        (memEn),
	.inPipe       (inPipe),
	.aluB         (aluB),
	.memData      (memData),
	.regValue     (bank.regValue)
);

// File: dv/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
	output logic CLK,
	output logic rst
);

	localparam time halfPeriod = 20ns; // 40 ns clock.

	initial
	begin
		CLK = 1'b0;
		forever #(halfPeriod) CLK = ~CLK;
	end

	// Reset spans five rising edges and drops on a falling edge.
	initial
	begin
		rst = 1'b1;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
	end

endmodule

// File: src/registerFile.sv
`timescale 1ns/1ps

`include "regFile_config.svh"

module registerFile import regFilePkg::*;
(
	input  logic     CLK,
	input  logic     rst,

	// Load sources and their strobes.
	input  dataWordT inAlu,
	input  regMaskT  ldAlu,
	input  dataWordT inMem,
	input  regMaskT  ldMem,
	input  dataWordT inPipe,
	input  regMaskT  ldPipe,
	input  regMaskT  inc, // Increment strobe per register.

	// Read selects.
	input  regIdxT   aluASel,
	input  regIdxT   aluBSel,
	input  logic     aluBFromPipe,
	input  logic     memEn,
	input  regIdxT   memSel,
	input  regIdxT   memAddrSel,

	// Read ports.
	output dataWordT aluA,
	output dataWordT aluB,
	output dataWordT memData,
	output dataWordT memAddr
);

	// Shared bank signals.
	regBankIf bank ();

	// Per-register action resolution.
	regLoadDecoder decoder (
		.ldAlu  (ldAlu),
		.ldMem  (ldMem),
		.ldPipe (ldPipe),
		.inc    (inc),
		.inAlu  (inAlu),
		.inMem  (inMem),
		.inPipe (inPipe),
		.bank   (bank.ctrl)
	);

	// The eight registers.
	for (genvar i = 0; i < `RF_NUM_REGS; i++)
	begin : gRegs
		gpRegister gpReg (
			.CLK  (CLK),
			.rst  (rst),
			.idx  (regIdxT'(i)), // Slot number.
			.bank (bank.bank)
		);
	end

	// Combinational read side.
	regReadMux readMux (
		.aluASel      (aluASel),
		.aluBSel      (aluBSel),
		.memSel       (memSel),
		.memAddrSel   (memAddrSel),
		.aluBFromPipe (aluBFromPipe),
		.memEn        (memEn),
		.inPipe       (inPipe),
		.bank         (bank.read),
		.aluA         (aluA),
		.aluB         (aluB),
		.memData      (memData),
		.memAddr      (memAddr)
	);

endmodule

// File: src/regReadMux.sv
`timescale 1ns/1ps

module regReadMux import regFilePkg::*;
(
	input  regIdxT   aluASel, // Register on ALU operand A.
	input  regIdxT   aluBSel, // Register on ALU operand B.
	input  regIdxT   memSel, // Register on memory write data.
	input  regIdxT   memAddrSel, // Register on memory address.
	input  logic     aluBFromPipe, // Operand B takes the constant instead.
	input  logic     memEn, // Memory data port is live.
	input  dataWordT inPipe,
	regBankIf.read   bank,
	output dataWordT aluA,
	output dataWordT aluB,
	output dataWordT memData,
	output dataWordT memAddr
);

	dataWordT aluBReg; // Register word for operand B before the bypass.
	dataWordT memReg; // Register word for memory data before the enable.

	// Operand A.
	assign aluA = bank.regValue[aluASel];

	// Operand B.
	assign aluBReg = bank.regValue[aluBSel];

	// Constant bypass.
	always_comb
	begin
		if (aluBFromPipe)
		begin
			aluB = inPipe;
		end
		else
		begin
			aluB = aluBReg;
		end
	end

	// Memory write data.
	// Reads zero when the memory side is not enabled.
	assign memReg = bank.regValue[memSel];

	always_comb
	begin
		if (memEn)
		begin
			memData = memReg;
		end
		else
		begin
			memData = '0;
		end
	end

	// Address bus, always driven.
	assign memAddr = bank.regValue[memAddrSel];

endmodule

// File: src/gpRegister.sv
`timescale 1ns/1ps

`include "regFile_config.svh"

module gpRegister import regFilePkg::*;
(
	input  logic   CLK,
	input  logic   rst,
	input  regIdxT idx, // Position of this register in the bank.
	regBankIf.bank bank
);

	dataWordT value; // Stored word.
	dataWordT loadWord; // Word picked by this register's source code.

	// Source select for a pending load.
	always_comb
	begin
		case (bank.loadSrc[idx])
			`RF_SRC_ALU:  loadWord = bank.inAlu;
			`RF_SRC_MEM:  loadWord = bank.inMem;
			`RF_SRC_PIPE: loadWord = bank.inPipe;
			default:      loadWord = value; // Unused code keeps the old word.
		endcase
	end

	// Clear, load, increment or hold.
	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			value <= '0;
		end
		else if (bank.loadEn[idx])
		begin
			value <= loadWord;
		end
		else if (bank.incEn[idx])
		begin
			value <= value + dataWordT'(1); // Wraps FFFF to 0000.
		end
	end

	// Own slot in the bank, read back by the multiplexer.
	assign bank.regValue[idx] = value;

endmodule

// File: src/regLoadDecoder.sv
`timescale 1ns/1ps

`include "regFile_config.svh"

module regLoadDecoder import regFilePkg::*;
(
	input  regMaskT  ldAlu, // Load from ALU result, one bit per register.
	input  regMaskT  ldMem, // Load from memory data.
	input  regMaskT  ldPipe, // Load from pipeline constant.
	input  regMaskT  inc, // Increment in place.
	input  dataWordT inAlu,
	input  dataWordT inMem,
	input  dataWordT inPipe,
	regBankIf.ctrl   bank
);

	// Any load at all, per register.
	regMaskT anyLoad;

	assign anyLoad = ldAlu | ldMem | ldPipe;

	// A load always beats an increment on the same register.
	assign bank.loadEn = anyLoad;
	assign bank.incEn  = inc & ~anyLoad;

	// Source words go straight through to every register.
	assign bank.inAlu  = inAlu;
	assign bank.inMem  = inMem;
	assign bank.inPipe = inPipe;

	// Pick one source per register.
	// ALU first, then memory, pipeline last.
	always_comb
	begin
		for (int i = 0; i < `RF_NUM_REGS; i++)
		begin
			if (ldAlu[i])
			begin
				bank.loadSrc[i] = `RF_SRC_ALU;
			end
			else if (ldMem[i])
			begin
				bank.loadSrc[i] = `RF_SRC_MEM;
			end
			else
			begin
				// Also the idle code, ignored while loadEn is low.
				bank.loadSrc[i] = `RF_SRC_PIPE;
			end
		end
	end

endmodule

// File: src/regBankIf.sv
`timescale 1ns/1ps

`include "regFile_config.svh"

interface regBankIf import regFilePkg::*; ();

	// Resolved per-register actions.
	regMaskT loadEn; // Register loads at the next edge.
	loadSrcT loadSrc [`RF_NUM_REGS]; // Winning source per register.
	regMaskT incEn; // Increment, only where no load is pending.

	// Shared source buses.
	dataWordT inAlu;
	dataWordT inMem;
	dataWordT inPipe;

	// Current contents, one entry per register.
	dataWordT regValue [`RF_NUM_REGS];

	// Decoder side, drives the actions and forwards the buses.
	modport ctrl (
		output loadEn,
		output loadSrc,
		output incEn,
		output inAlu,
		output inMem,
		output inPipe
	);

	// Register side.
	modport bank (
		input  loadEn,
		input  loadSrc,
		input  incEn,
		input  inAlu,
		input  inMem,
		input  inPipe,
		output regValue
	);

	// Read multiplexer only needs the contents.
	modport read (
		input regValue
	);

endinterface

// File: src/regFilePkg.sv
package regFilePkg;

	`include "regFile_config.svh"

	// One word on any of the datapath buses.
	typedef logic [`RF_DATA_BITS-1:0] dataWordT;

	// Index of one general register.
	typedef logic [`RF_REG_BITS-1:0] regIdxT;

	// One bit per register, bit n belongs to register n.
	typedef logic [`RF_NUM_REGS-1:0] regMaskT;

	// Which bus a register loads from.
	typedef logic [`RF_SRC_BITS-1:0] loadSrcT;

endpackage

// File: include/regFile_config.svh
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// Width of a register index.
`define RF_REG_BITS 3

// Width of one datapath word.
`define RF_DATA_BITS 16

// One register for every index value.
`define RF_NUM_REGS (2 ** `RF_REG_BITS)

// Load source encoding.
`define RF_SRC_BITS 2
`define RF_SRC_ALU  2'd0 // ALU result bus.
`define RF_SRC_MEM  2'd1 // Memory read data.
`define RF_SRC_PIPE 2'd2 // Constant from the instruction word.

`endif
